// File: design/FetchPkg.sv
`default_nettype none

package FetchPkg;

  // first fetch address after reset
  localparam logic [31:0] resetPc = 32'h0000_0000;

  // pattern history table geometry
  localparam int phtEntries   = 64;
  localparam int phtIndexBits = 6;

  // BTB geometry, tag is everything above index and byte offset
  localparam int btbEntries   = 16;
  localparam int btbIndexBits = 4;
  localparam int btbTagBits   = 26;

  // branch-class opcodes
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;

  // weakly not taken
  localparam logic [1:0] counterInit = 2'b01;

  // fetch handshake FSM encoding
  localparam logic [1:0] fetchIdle    = 2'd0;
  localparam logic [1:0] fetchRequest = 2'd1;
  localparam logic [1:0] fetchRelease = 2'd2;

  // one instruction word, seen as raw bits or as B/J immediate layouts
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
    } bType;
    struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } jType;
  } instWord_t;

endpackage

`default_nettype wire

// File: design/BranchDirPredictor.sv
`default_nettype none

module BranchDirPredictor (
  input  logic        clk,
  input  logic        arstN,
  input  logic [31:0] lookupPc,
  input  logic        updateValid,
  input  logic [31:0] updatePc,
  input  logic        updateTaken,
  output logic        predTaken
);

  logic [1:0] pht [FetchPkg::phtEntries];

  logic [FetchPkg::phtIndexBits-1:0] lookupIdx;
  logic [FetchPkg::phtIndexBits-1:0] updateIdx;
  logic [1:0]                        curCount;

  // word-aligned PC bits select the counter
  assign lookupIdx = lookupPc[FetchPkg::phtIndexBits+1:2];
  assign updateIdx = updatePc[FetchPkg::phtIndexBits+1:2];

  // upper counter bit gives the direction
  assign predTaken = pht[lookupIdx][1];

  assign curCount = pht[updateIdx];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < FetchPkg::phtEntries; i++) begin
        pht[i] <= FetchPkg::counterInit;
      end
    end else if (updateValid) begin
      // one step toward the outcome, saturating at both ends
      if (updateTaken) begin
        if (curCount != 2'b11) begin
          pht[updateIdx] <= curCount + 2'd1;
        end
      end else begin
        if (curCount != 2'b00) begin
          pht[updateIdx] <= curCount - 2'd1;
        end
      end
    end
  end

  // training from execute must carry a real PC
  updatePcKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    updateValid |-> !$isunknown(updatePc)
  ) else $error("predictor update with unknown PC");

endmodule

`default_nettype wire

// File: design/BranchTargetBuffer.sv
`default_nettype none

module BranchTargetBuffer (
  input  logic        clk,
  input  logic        arstN,
  input  logic [31:0] lookupPc,
  input  logic        updateValid,
  input  logic [31:0] updatePc,
  input  logic        updateTaken,
  input  logic [31:0] updateTarget,
  output logic        btbHit,
  output logic [31:0] btbTarget
);

  logic [FetchPkg::btbEntries-1:0] entryValid;
  logic [FetchPkg::btbTagBits-1:0] entryTag    [FetchPkg::btbEntries];
  logic [31:0]                     entryTarget [FetchPkg::btbEntries];

  logic [FetchPkg::btbIndexBits-1:0] lookupIdx;
  logic [FetchPkg::btbIndexBits-1:0] updateIdx;
  logic [FetchPkg::btbTagBits-1:0]   lookupTag;
  logic [FetchPkg::btbTagBits-1:0]   updateTag;
  logic                              allocate;

  // index right above the byte offset, tag is the rest
  assign lookupIdx = lookupPc[FetchPkg::btbIndexBits+1:2];
  assign updateIdx = updatePc[FetchPkg::btbIndexBits+1:2];
  assign lookupTag = lookupPc[31 -: FetchPkg::btbTagBits];
  assign updateTag = updatePc[31 -: FetchPkg::btbTagBits];

  // only taken branches are worth a slot
  assign allocate = updateValid && updateTaken;

  assign btbHit    = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);
  assign btbTarget = entryTarget[lookupIdx];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      entryValid <= '0;
    end else if (allocate) begin
      entryValid[updateIdx] <= 1'b1;
    end
  end

  // tag and target storage
  always_ff @(posedge clk) begin
    if (allocate) begin
      entryTag[updateIdx]    <= updateTag;
      entryTarget[updateIdx] <= updateTarget;
    end
  end

  // a misaligned target would send fetch off the word grid
  targetAligned: assert property (
    @(posedge clk) disable iff (!arstN)
    allocate |-> (updateTarget[1:0] == 2'b00)
  ) else $error("BTB allocation with misaligned target");

endmodule

`default_nettype wire

// File: design/FetchStage.sv
`default_nettype none

module FetchStage (
  input  logic        clk,
  input  logic        arstN,
  // instruction memory
  output logic        instReq,
  output logic [31:0] instAddr,
  input  logic        instAck,
  input  logic [31:0] instData,
  // predictor and BTB lookup
  output logic [31:0] lookupPc,
  input  logic        predTaken,
  input  logic        btbHit,
  input  logic [31:0] btbTarget,
  // control from later stages
  input  logic        redirectValid,
  input  logic [31:0] redirectPc,
  input  logic        dataHazard,
  // decode pipeline register
  output logic        outValid,
  output logic [31:0] outPc,
  output logic [31:0] outInst,
  output logic        outPredTaken,
  output logic        outNextPcPredicted,
  output logic [31:0] outPredTarget
);

  logic [1:0]  state;
  logic [31:0] pc;
  logic [31:0] reqAddr;
  logic        hazardWait;
  logic        discard;

  // result parked while decode is stalled
  logic        bufValid;
  logic [31:0] bufInst;
  logic        bufPredTaken;
  logic        bufBtbHit;
  logic [31:0] bufBtbTarget;

  logic        ackSeen;
  logic        liveCapture;
  logic        bufLoad;
  logic        accept;
  logic        startReq;

  logic [31:0] srcInst;
  logic        srcPredTaken;
  logic        srcBtbHit;
  logic [31:0] srcBtbTarget;

  FetchPkg::instWord_t word;
  logic        branchClass;
  logic        isBranch;
  logic        isJal;
  logic        isJalr;
  logic [31:0] bImm;
  logic [31:0] jImm;
  logic [31:0] pcPlus4;
  logic        takenPred;
  logic        enterWait;
  logic        nextPcPredicted;
  logic [31:0] nextPc;
  logic [31:0] predTarget;

  assign instReq  = (state == FetchPkg::fetchRequest);
  assign instAddr = reqAddr;
  assign lookupPc = reqAddr;

  assign ackSeen     = instReq && instAck;
  // data of a handshake overtaken by a redirect is dropped
  assign liveCapture = ackSeen && !discard && !redirectValid;
  assign bufLoad     = liveCapture && dataHazard;
  assign accept      = (bufValid || liveCapture) && !dataHazard && !redirectValid;
  assign startReq    = (state == FetchPkg::fetchIdle) && !dataHazard && !hazardWait &&
                       !bufValid && !redirectValid;

  // buffered copy wins, a new request never opens while it is held
  assign srcInst      = bufValid ? bufInst      : instData;
  assign srcPredTaken = bufValid ? bufPredTaken : predTaken;
  assign srcBtbHit    = bufValid ? bufBtbHit    : btbHit;
  assign srcBtbTarget = bufValid ? bufBtbTarget : btbTarget;

  // predecode
  assign word.raw    = srcInst;
  assign branchClass = word.raw[6];
  assign isBranch    = branchClass && (word.bType.opcode == FetchPkg::opBranch);
  assign isJal       = branchClass && (word.jType.opcode == FetchPkg::opJal);
  assign isJalr      = branchClass && (word.raw[6:0] == FetchPkg::opJalr);

  assign bImm = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
                 word.bType.imm10to5, word.bType.imm4to1, 1'b0};
  assign jImm = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.imm19to12,
                 word.jType.imm11, word.jType.imm10to1, 1'b0};

  assign pcPlus4   = pc + 32'd4;
  assign takenPred = isJal || ((isBranch || isJalr) && srcPredTaken);

  always_comb begin
    nextPc          = pcPlus4;
    predTarget      = pcPlus4;
    nextPcPredicted = 1'b0;
    enterWait       = 1'b0;
    if (takenPred) begin
      if (srcBtbHit) begin
        nextPc          = srcBtbTarget;
        predTarget      = srcBtbTarget;
        nextPcPredicted = 1'b1;
      end else if (isJalr) begin
        // register target unknown here, wait for execute
        nextPc     = pc;
        predTarget = '0;
        enterWait  = 1'b1;
      end else begin
        nextPc          = pc + (isJal ? jImm : bImm);
        predTarget      = nextPc;
        nextPcPredicted = 1'b1;
      end
    end
  end

  // four-phase handshake, never aborted
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= FetchPkg::fetchIdle;
      reqAddr <= FetchPkg::resetPc;
    end else begin
      case (state)
        FetchPkg::fetchIdle: begin
          if (startReq) begin
            state   <= FetchPkg::fetchRequest;
            reqAddr <= pc;
          end
        end
        FetchPkg::fetchRequest: begin
          if (instAck) begin
            state <= FetchPkg::fetchRelease;
          end
        end
        FetchPkg::fetchRelease: begin
          if (!instAck) begin
            state <= FetchPkg::fetchIdle;
          end
        end
        default: state <= FetchPkg::fetchIdle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc         <= FetchPkg::resetPc;
      hazardWait <= 1'b0;
      discard    <= 1'b0;
      bufValid   <= 1'b0;
      outValid   <= 1'b0;
    end else if (redirectValid) begin
      pc         <= redirectPc;
      hazardWait <= 1'b0;
      bufValid   <= 1'b0;
      outValid   <= 1'b0;
      // an open request finishes but its word is thrown away
      discard    <= instReq && !instAck;
    end else begin
      if (ackSeen) begin
        discard <= 1'b0;
      end
      if (bufLoad) begin
        bufValid <= 1'b1;
      end
      if (accept) begin
        pc         <= nextPc;
        hazardWait <= enterWait;
        bufValid   <= 1'b0;
        outValid   <= 1'b1;
      end else if (!dataHazard) begin
        outValid <= 1'b0;
      end
    end
  end

  // stall buffer payload
  always_ff @(posedge clk) begin
    if (bufLoad) begin
      bufInst      <= instData;
      bufPredTaken <= predTaken;
      bufBtbHit    <= btbHit;
      bufBtbTarget <= btbTarget;
    end
  end

  // decode pipeline register payload
  always_ff @(posedge clk) begin
    if (accept) begin
      outPc              <= pc;
      outInst            <= srcInst;
      outPredTaken       <= takenPred;
      outNextPcPredicted <= nextPcPredicted;
      outPredTarget      <= predTarget;
    end
  end

  // request must be held until memory answers
  reqHeld: assert property (
    @(posedge clk) disable iff (!arstN)
    instReq && !instAck |=> instReq
  ) else $error("instReq dropped before instAck");

  reqAddrStable: assert property (
    @(posedge clk) disable iff (!arstN)
    instReq && !instAck |=> $stable(instAddr)
  ) else $error("instAddr changed during open request");

endmodule

`default_nettype wire

// File: design/FetchUnit.sv
`default_nettype none

module FetchUnit (
  input  logic        clk,
  input  logic        arstN,
  // instruction memory
  output logic        instReq,
  output logic [31:0] instAddr,
  input  logic        instAck,
  input  logic [31:0] instData,
  // redirect and stall
  input  logic        redirectValid,
  input  logic [31:0] redirectPc,
  input  logic        dataHazard,
  // training from resolved branches
  input  logic        updateValid,
  input  logic [31:0] updatePc,
  input  logic        updateTaken,
  input  logic [31:0] updateTarget,
  // to decode
  output logic        outValid,
  output logic [31:0] outPc,
  output logic [31:0] outInst,
  output logic        outPredTaken,
  output logic        outNextPcPredicted,
  output logic [31:0] outPredTarget
);

  logic [31:0] lookupPc;
  logic        predTaken;
  logic        btbHit;
  logic [31:0] btbTarget;

  BranchDirPredictor dirPred_i (
    .clk         (clk),
    .arstN       (arstN),
    .lookupPc    (lookupPc),
    .updateValid (updateValid),
    .updatePc    (updatePc),
    .updateTaken (updateTaken),
    .predTaken   (predTaken)
  );

  BranchTargetBuffer btb_i (
    .clk          (clk),
    .arstN        (arstN),
    .lookupPc     (lookupPc),
    .updateValid  (updateValid),
    .updatePc     (updatePc),
    .updateTaken  (updateTaken),
    .updateTarget (updateTarget),
    .btbHit       (btbHit),
    .btbTarget    (btbTarget)
  );

  FetchStage fetch_i (
    .clk                (clk),
    .arstN              (arstN),
    .instReq            (instReq),
    .instAddr           (instAddr),
    .instAck            (instAck),
    .instData           (instData),
    .lookupPc           (lookupPc),
    .predTaken          (predTaken),
    .btbHit             (btbHit),
    .btbTarget          (btbTarget),
    .redirectValid      (redirectValid),
    .redirectPc         (redirectPc),
    .dataHazard         (dataHazard),
    .outValid           (outValid),
    .outPc              (outPc),
    .outInst            (outInst),
    .outPredTaken       (outPredTaken),
    .outNextPcPredicted (outNextPcPredicted),
    .outPredTarget      (outPredTarget)
  );

endmodule

`default_nettype wire

// File: dv/FetchRefModel.svh
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// hashed program image, about a third branch-class with short offsets
function automatic logic [31:0] memWord(input logic [31:0] addr);
  logic [31:0]         h;
  logic [4:0]          k;
  logic [12:0]         bOff;
  logic [20:0]         jOff;
  FetchPkg::instWord_t w;
  h = addr * 32'h9e37_79b1;
  h = h ^ (h >> 15);
  h = h * 32'h85eb_ca6b;
  h = h ^ (h >> 13);
  w.raw = h;
  // offset in words, never zero so no jump lands on itself
  k = h[20:16];
  if (k == 5'd0) begin
    k = 5'd2;
  end
  bOff = {{6{k[4]}}, k, 2'b00};
  jOff = {{14{k[4]}}, k, 2'b00};
  if ((h % 3) != 0) begin
    // plain words, opcode bit 6 always clear
    case (h[2:0])
      3'd2:    w.raw[6:0] = 7'b0110011;
      3'd3:    w.raw[6:0] = 7'b0000011;
      3'd4:    w.raw[6:0] = 7'b0100011;
      3'd5:    w.raw[6:0] = 7'b0110111;
      3'd6:    w.raw[6:0] = 7'b0010111;
      default: w.raw[6:0] = 7'b0010011;
    endcase
  end else if (!h[5]) begin
    w.bType.imm12    = bOff[12];
    w.bType.imm11    = bOff[11];
    w.bType.imm10to5 = bOff[10:5];
    w.bType.imm4to1  = bOff[4:1];
    w.bType.funct3   = {h[25], 1'b0, h[24]};
    w.bType.opcode   = FetchPkg::opBranch;
  end else if (!h[4]) begin
    w.jType.imm20     = jOff[20];
    w.jType.imm19to12 = jOff[19:12];
    w.jType.imm11     = jOff[11];
    w.jType.imm10to1  = jOff[10:1];
    w.jType.opcode    = FetchPkg::opJal;
  end else begin
    w.raw[14:12] = 3'b000;
    w.raw[6:0]   = FetchPkg::opJalr;
  end
  return w.raw;
endfunction

function automatic logic [31:0] branchOffset(input FetchPkg::instWord_t w);
  logic [12:0] off;
  off = {w.bType.imm12, w.bType.imm11, w.bType.imm10to5, w.bType.imm4to1, 1'b0};
  return {{19{off[12]}}, off};
endfunction

function automatic logic [31:0] jumpOffset(input FetchPkg::instWord_t w);
  logic [20:0] off;
  off = {w.jType.imm20, w.jType.imm19to12, w.jType.imm11, w.jType.imm10to1, 1'b0};
  return {{11{off[20]}}, off};
endfunction

// next-PC rule for one accepted word
function automatic void predictNext(
  input  logic [31:0] pc,
  input  logic [31:0] inst,
  input  logic        ctrTaken,
  input  logic        hit,
  input  logic [31:0] hitTarget,
  output logic        taken,
  output logic        nextPredicted,
  output logic [31:0] target,
  output logic [31:0] nextPc,
  output logic        jalrWait
);
  FetchPkg::instWord_t w;
  logic                isBranch;
  logic                isJal;
  logic                isJalr;
  w.raw         = inst;
  isBranch      = (w.bType.opcode == FetchPkg::opBranch);
  isJal         = (w.jType.opcode == FetchPkg::opJal);
  isJalr        = (w.raw[6:0] == FetchPkg::opJalr);
  taken         = isJal || ((isBranch || isJalr) && ctrTaken);
  nextPc        = pc + 32'd4;
  target        = pc + 32'd4;
  nextPredicted = 1'b0;
  jalrWait      = 1'b0;
  if (taken && hit) begin
    nextPc        = hitTarget;
    target        = hitTarget;
    nextPredicted = 1'b1;
  end else if (taken && isJalr) begin
    target   = 32'd0;
    jalrWait = 1'b1;
  end else if (taken) begin
    nextPc        = pc + (isJal ? jumpOffset(w) : branchOffset(w));
    target        = nextPc;
    nextPredicted = 1'b1;
  end
endfunction

// mirrors follow the same training as the DUT tables
task automatic trainMirrors(input logic [31:0] pc, input logic taken, input logic [31:0] target);
  logic [FetchPkg::phtIndexBits-1:0] pIdx;
  logic [FetchPkg::btbIndexBits-1:0] bIdx;
  pIdx = pc[FetchPkg::phtIndexBits+1:2];
  bIdx = pc[FetchPkg::btbIndexBits+1:2];
  if (taken) begin
    if (phtMirror[pIdx] != 2'b11) begin
      phtMirror[pIdx] = phtMirror[pIdx] + 2'd1;
    end
    btbValidM[bIdx]  = 1'b1;
    btbTagM[bIdx]    = pc[31 -: FetchPkg::btbTagBits];
    btbTargetM[bIdx] = target;
  end else if (phtMirror[pIdx] != 2'b00) begin
    phtMirror[pIdx] = phtMirror[pIdx] - 2'd1;
  end
endtask

`endif

// File: dv/FetchUnitTb.sv
`default_nettype none

module FetchUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numInstr       = 2000;
  localparam int cyclesPerInstr = 12;
  localparam int resetCycles    = 4;
  localparam int clkPeriodNs    = 8;

  logic        clk;
  logic        arstN;
  logic        instReq;
  logic [31:0] instAddr;
  logic        instAck;
  logic [31:0] instData;
  logic        redirectValid;
  logic [31:0] redirectPc;
  logic        dataHazard;
  logic        updateValid;
  logic [31:0] updatePc;
  logic        updateTaken;
  logic [31:0] updateTarget;
  logic        outValid;
  logic [31:0] outPc;
  logic [31:0] outInst;
  logic        outPredTaken;
  logic        outNextPcPredicted;
  logic [31:0] outPredTarget;

  // predictor and BTB mirrors
  logic [1:0]                      phtMirror  [FetchPkg::phtEntries];
  logic [FetchPkg::btbEntries-1:0] btbValidM;
  logic [FetchPkg::btbTagBits-1:0] btbTagM    [FetchPkg::btbEntries];
  logic [31:0]                     btbTargetM [FetchPkg::btbEntries];

  // fetch model state
  logic [31:0] rngState;
  logic [31:0] expPc;
  logic        waitJalr;
  logic        dropPending;
  logic        pendValid;
  logic [31:0] pendPc;
  logic [31:0] pendInst;
  logic        pendTaken;
  logic        pendNpp;
  logic [31:0] pendTarget;
  logic [31:0] pendNext;
  logic        pendWait;
  logic        expValid;
  logic        expFresh;
  logic [31:0] expOutPc;
  logic [31:0] expOutInst;
  logic        expOutTaken;
  logic        expOutNpp;
  logic [31:0] expOutTarget;
  int          checkedCount;
  int          ackDelay;
  logic        delayArmed;

  `include "FetchRefModel.svh"

  FetchUnit dut_i (
    .clk                (clk),
    .arstN              (arstN),
    .instReq            (instReq),
    .instAddr           (instAddr),
    .instAck            (instAck),
    .instData           (instData),
    .redirectValid      (redirectValid),
    .redirectPc         (redirectPc),
    .dataHazard         (dataHazard),
    .updateValid        (updateValid),
    .updatePc           (updatePc),
    .updateTaken        (updateTaken),
    .updateTarget       (updateTarget),
    .outValid           (outValid),
    .outPc              (outPc),
    .outInst            (outInst),
    .outPredTaken       (outPredTaken),
    .outNextPcPredicted (outNextPcPredicted),
    .outPredTarget      (outPredTarget)
  );

  always #(clkPeriodNs / 2) clk = !clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic logic rollPercent(input int pct);
    return (nextRandom() % 100) < pct;
  endfunction

  task automatic checkEq(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // sampled mid-cycle, then the model steps over the coming edge
  task automatic observeCycle();
    logic                              liveAck;
    logic                              hit;
    logic [FetchPkg::btbIndexBits-1:0] bIdx;
    logic [FetchPkg::phtIndexBits-1:0] pIdx;
    checkEq("outValid", 32'(outValid), 32'(expValid));
    if (expValid) begin
      checkEq("outPc", outPc, expOutPc);
      checkEq("outInst", outInst, expOutInst);
      checkEq("outPredTaken", 32'(outPredTaken), 32'(expOutTaken));
      checkEq("outNextPcPredicted", 32'(outNextPcPredicted), 32'(expOutNpp));
      checkEq("outPredTarget", outPredTarget, expOutTarget);
      if (expFresh) begin
        checkedCount++;
        expFresh = 1'b0;
      end
    end
    // nothing goes out to memory during a JALR wait
    if (waitJalr) begin
      checkEq("instReq", 32'(instReq), 32'd0);
    end
    liveAck = instReq && instAck && !dropPending && !redirectValid;
    if (redirectValid) begin
      expPc       = redirectPc;
      waitJalr    = 1'b0;
      pendValid   = 1'b0;
      expValid    = 1'b0;
      dropPending = instReq && !instAck;
    end else begin
      if (instReq && instAck) begin
        dropPending = 1'b0;
      end
      if (liveAck) begin
        checkEq("instAddr", instAddr, expPc);
        bIdx = expPc[FetchPkg::btbIndexBits+1:2];
        pIdx = expPc[FetchPkg::phtIndexBits+1:2];
        hit  = btbValidM[bIdx] && (btbTagM[bIdx] == expPc[31 -: FetchPkg::btbTagBits]);
        pendPc    = expPc;
        pendInst  = memWord(expPc);
        pendValid = 1'b1;
        predictNext(expPc, pendInst, phtMirror[pIdx][1], hit, btbTargetM[bIdx],
                    pendTaken, pendNpp, pendTarget, pendNext, pendWait);
      end
      if (pendValid && !dataHazard) begin
        expValid     = 1'b1;
        expFresh     = 1'b1;
        expOutPc     = pendPc;
        expOutInst   = pendInst;
        expOutTaken  = pendTaken;
        expOutNpp    = pendNpp;
        expOutTarget = pendTarget;
        expPc        = pendNext;
        waitJalr     = pendWait;
        pendValid    = 1'b0;
      end else if (!dataHazard) begin
        expValid = 1'b0;
      end
    end
    if (updateValid) begin
      trainMirrors(updatePc, updateTaken, updateTarget);
    end
  endtask

  task automatic driveInputs();
    logic [31:0] r;
    // memory responder, ack held until the request drops
    if (instAck && !instReq) begin
      instAck  = 1'b0;
      instData = nextRandom();
    end else if (instReq && !instAck) begin
      if (!delayArmed) begin
        ackDelay   = nextRandom() % 4;
        delayArmed = 1'b1;
      end
      if (ackDelay == 0) begin
        instAck    = 1'b1;
        instData   = memWord(instAddr);
        delayArmed = 1'b0;
      end else begin
        ackDelay--;
      end
    end
    dataHazard    = rollPercent(15);
    redirectValid = rollPercent(waitJalr ? 50 : 5);
    r             = nextRandom();
    redirectPc    = {22'd0, r[9:2], 2'b00};
    updateValid   = rollPercent(20);
    r             = nextRandom();
    // training window covers every counter and a few BTB tags
    updatePc      = {24'd0, r[7:2], 2'b00};
    updateTaken   = (r[10:8] < 3'd5);
    updateTarget  = {22'd0, r[31:24], 2'b00};
  endtask

  initial begin
    #((numInstr * cyclesPerInstr + resetCycles) * clkPeriodNs);
    $display("Timeout: %0d instructions did not complete in the allowed time", numInstr);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rngState      = 32'hb40;
    clk           = 1'b0;
    arstN         = 1'b0;
    instAck       = 1'b0;
    instData      = 32'd0;
    redirectValid = 1'b0;
    redirectPc    = 32'd0;
    dataHazard    = 1'b0;
    updateValid   = 1'b0;
    updatePc      = 32'd0;
    updateTaken   = 1'b0;
    updateTarget  = 32'd0;
    foreach (phtMirror[i]) begin
      phtMirror[i] = FetchPkg::counterInit;
    end
    btbValidM    = '0;
    expPc        = FetchPkg::resetPc;
    waitJalr     = 1'b0;
    dropPending  = 1'b0;
    pendValid    = 1'b0;
    expValid     = 1'b0;
    expFresh     = 1'b0;
    checkedCount = 0;
    ackDelay     = 0;
    delayArmed   = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
    while (checkedCount < numInstr) begin
      @(negedge clk);
      observeCycle();
      @(posedge clk);
      #1;
      driveInputs();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
design/FetchPkg.sv
design/BranchDirPredictor.sv
design/BranchTargetBuffer.sv
design/FetchStage.sv
design/FetchUnit.sv
dv/FetchUnitTb.sv

// File: Makefile
# Verilator flow for the fetch unit testbench
TOP = FetchUnitTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
